//--- Makefile
VERILATOR ?= verilator
FLAGS     = --timing --assert
TOP       = wired_decode_stage_tb
FLIST     = flist.f
MDIR      = obj_dir
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(MDIR)
	./$(MDIR)/V$(TOP) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(MDIR) $(LOG)

//--- flist.f
+incdir+hdl
hdl/wired_pkg.sv
hdl/wired_branch_decoder.sv
hdl/wired_imm_alu_decoder.sv
hdl/wired_reg_alu_decoder.sv
hdl/wired_decode_stage.sv
verif/wired_decode_stage_props.sv
verif/wired_decode_stage_tb.sv

//--- hdl/wired_branch_decoder.sv
`include "wired_cfg.svh"

module wired_branch_decoder (
    input  wired_pkg::inst_t    inst_i,
    output logic                hit_o,
    output wired_pkg::decoded_t dec_o
);

    wired_pkg::op6_t op6;

    assign op6 = inst_i[`WIRED_OP6_MSB:`WIRED_OP6_LSB];

    always_comb begin
        dec_o = wired_pkg::dec_default;
        dec_o.inst = inst_i;
        dec_o.jump_inst = 1'b1;
        dec_o.target_type = wired_pkg::target_rel;
        hit_o = 1'b1;
        unique case (op6)
            6'b010011: begin
                // jirl, target is rj plus offset, pc+4 into rd
                dec_o.reg_type_r1 = wired_pkg::reg_r1_rj;
                dec_o.reg_type_w = wired_pkg::reg_w_rd;
                dec_o.addr_imm_type = wired_pkg::addr_imm_s16;
                dec_o.alu_grand_op = wired_pkg::alu_grand_li;
                dec_o.alu_op = wired_pkg::alu_op_pcplus4;
                dec_o.target_type = wired_pkg::target_abs;
            end
            6'b010100: dec_o.addr_imm_type = wired_pkg::addr_imm_s26;
            6'b010101: begin
                // bl links into r1
                dec_o.reg_type_w = wired_pkg::reg_w_bl1;
                dec_o.addr_imm_type = wired_pkg::addr_imm_s26;
                dec_o.alu_grand_op = wired_pkg::alu_grand_li;
                dec_o.alu_op = wired_pkg::alu_op_pcplus4;
            end
            6'b010110: dec_o.cmp_type = wired_pkg::cmp_eq;
            6'b010111: dec_o.cmp_type = wired_pkg::cmp_ne;
            6'b011000: dec_o.cmp_type = wired_pkg::cmp_lt;
            6'b011001: dec_o.cmp_type = wired_pkg::cmp_ge;
            6'b011010: dec_o.cmp_type = wired_pkg::cmp_ltu;
            6'b011011: dec_o.cmp_type = wired_pkg::cmp_geu;
            default:   hit_o = 1'b0;
        endcase
        // conditional branches compare rd against rj
        if (dec_o.cmp_type != wired_pkg::cmp_nocond) begin
            dec_o.reg_type_r0 = wired_pkg::reg_r0_rd;
            dec_o.reg_type_r1 = wired_pkg::reg_r1_rj;
            dec_o.addr_imm_type = wired_pkg::addr_imm_s16;
        end
        if (!hit_o) begin
            dec_o = wired_pkg::dec_default;
            dec_o.inst = inst_i;
        end
    end

endmodule

//--- hdl/wired_cfg.svh
`ifndef WIRED_CFG_SVH
`define WIRED_CFG_SVH

// instruction word
`define WIRED_INST_W 32

// branch condition code width
`define WIRED_CMP_W 4

// alu sub-op and mdu op widths
`define WIRED_ALU_OP_W 2
`define WIRED_MDU_OP_W 3

// major opcode, bits 31..26
`define WIRED_OP6_MSB 31
`define WIRED_OP6_LSB 26

// longer opcode fields, all starting at the top bit
`define WIRED_OP7_LSB 25
`define WIRED_OP10_LSB 22
`define WIRED_OP17_LSB 15

`endif

//--- hdl/wired_decode_stage.sv
module wired_decode_stage (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                inst_valid_i,
    input  wired_pkg::inst_t    inst_i,
    output logic                decoded_valid_o,
    output wired_pkg::decoded_t decoded_o,
    output logic                decode_err_o
);

    wired_pkg::group_out_t branch_grp;
    wired_pkg::group_out_t imm_alu_grp;
    wired_pkg::group_out_t reg_alu_grp;
    wired_pkg::decoded_t   dec_sel;
    logic                  hit_any;

    wired_branch_decoder u_branch (
        .inst_i (inst_i),
        .hit_o  (branch_grp.hit),
        .dec_o  (branch_grp.dec)
    );

    wired_imm_alu_decoder u_imm_alu (
        .inst_i (inst_i),
        .hit_o  (imm_alu_grp.hit),
        .dec_o  (imm_alu_grp.dec)
    );

    wired_reg_alu_decoder u_reg_alu (
        .inst_i (inst_i),
        .hit_o  (reg_alu_grp.hit),
        .dec_o  (reg_alu_grp.dec)
    );

    assign hit_any = branch_grp.hit | imm_alu_grp.hit | reg_alu_grp.hit;

    // group encodings are disjoint, order does not matter
    always_comb begin
        dec_sel = wired_pkg::dec_default;
        dec_sel.inst = inst_i;
        if (branch_grp.hit) begin
            dec_sel = branch_grp.dec;
        end else if (imm_alu_grp.hit) begin
            dec_sel = imm_alu_grp.dec;
        end else if (reg_alu_grp.hit) begin
            dec_sel = reg_alu_grp.dec;
        end
    end

    // id latch, holds its bundle across bubbles
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            decoded_valid_o <= 1'b0;
            decode_err_o    <= 1'b0;
            decoded_o       <= wired_pkg::dec_default;
        end else begin
            decoded_valid_o <= inst_valid_i;
            if (inst_valid_i) begin
                decoded_o    <= dec_sel;
                decode_err_o <= ~hit_any;
            end
        end
    end

endmodule

//--- hdl/wired_imm_alu_decoder.sv
`include "wired_cfg.svh"

module wired_imm_alu_decoder (
    input  wired_pkg::inst_t    inst_i,
    output logic                hit_o,
    output wired_pkg::decoded_t dec_o
);

    wired_pkg::op7_t  op7;
    wired_pkg::op10_t op10;
    wired_pkg::op17_t op17;

    assign op7  = inst_i[`WIRED_OP6_MSB:`WIRED_OP7_LSB];
    assign op10 = inst_i[`WIRED_OP6_MSB:`WIRED_OP10_LSB];
    assign op17 = inst_i[`WIRED_OP6_MSB:`WIRED_OP17_LSB];

    always_comb begin
        dec_o = wired_pkg::dec_default;
        dec_o.inst = inst_i;
        dec_o.alu_inst = 1'b1;
        dec_o.reg_type_r0 = wired_pkg::reg_r0_imm;
        dec_o.reg_type_r1 = wired_pkg::reg_r1_rj;
        dec_o.reg_type_w = wired_pkg::reg_w_rd;
        hit_o = 1'b1;
        if (op7 == 7'b0001010 || op7 == 7'b0001110) begin
            // lu12i and pcaddu12i, no register source
            dec_o.reg_type_r1 = wired_pkg::reg_r1_none;
            dec_o.imm_type = wired_pkg::imm_s20;
            dec_o.alu_grand_op = wired_pkg::alu_grand_li;
            dec_o.alu_op = op7[2] ? wired_pkg::alu_op_pcaddui : wired_pkg::alu_op_lui;
        end else if (op10[9:3] == 7'b0000001) begin
            // bit 2 splits signed arith from unsigned bitwise
            dec_o.imm_type = op10[2] ? wired_pkg::imm_u12 : wired_pkg::imm_s12;
            dec_o.alu_grand_op = op10[2] ? wired_pkg::alu_grand_bw : wired_pkg::alu_grand_int;
            unique case (op10[2:0])
                3'b000:  dec_o.alu_op = wired_pkg::alu_op_slt;
                3'b001:  dec_o.alu_op = wired_pkg::alu_op_sltu;
                3'b010:  dec_o.alu_op = wired_pkg::alu_op_add;
                3'b101:  dec_o.alu_op = wired_pkg::alu_op_and;
                3'b110:  dec_o.alu_op = wired_pkg::alu_op_or;
                3'b111:  dec_o.alu_op = wired_pkg::alu_op_xor;
                default: hit_o = 1'b0;
            endcase
        end else begin
            // shift by 5-bit immediate
            dec_o.imm_type = wired_pkg::imm_u5;
            dec_o.alu_grand_op = wired_pkg::alu_grand_sft;
            unique case (op17)
                17'b00000000010000001: dec_o.alu_op = wired_pkg::alu_op_sll;
                17'b00000000010001001: dec_o.alu_op = wired_pkg::alu_op_srl;
                17'b00000000010010001: dec_o.alu_op = wired_pkg::alu_op_sra;
                default:               hit_o = 1'b0;
            endcase
        end
        if (!hit_o) begin
            dec_o = wired_pkg::dec_default;
            dec_o.inst = inst_i;
        end
    end

endmodule

//--- hdl/wired_pkg.sv
`include "wired_cfg.svh"

package wired_pkg;

    typedef logic [`WIRED_INST_W-1:0] inst_t;

    // opcode fields, all anchored at the top of the word
    typedef logic [`WIRED_OP6_MSB-`WIRED_OP6_LSB:0] op6_t;
    typedef logic [`WIRED_OP6_MSB-`WIRED_OP7_LSB:0] op7_t;
    typedef logic [`WIRED_OP6_MSB-`WIRED_OP10_LSB:0] op10_t;
    typedef logic [`WIRED_OP6_MSB-`WIRED_OP17_LSB:0] op17_t;

    typedef enum logic [1:0] {reg_r0_none, reg_r0_rk, reg_r0_rd, reg_r0_imm} reg_r0_e;
    typedef enum logic {reg_r1_none, reg_r1_rj} reg_r1_e;
    // bl1 writes the link register r1
    typedef enum logic [1:0] {reg_w_none, reg_w_rd, reg_w_bl1} reg_w_e;

    typedef enum logic [1:0] {imm_u5, imm_u12, imm_s12, imm_s20} imm_e;
    typedef enum logic {addr_imm_s16, addr_imm_s26} addr_imm_e;

    typedef enum logic [1:0] {alu_grand_li, alu_grand_int, alu_grand_bw, alu_grand_sft} alu_grand_e;

    // sub-op, meaning depends on the family
    typedef logic [`WIRED_ALU_OP_W-1:0] alu_op_t;

    localparam alu_op_t alu_op_pcplus4 = 2'd0;
    localparam alu_op_t alu_op_lui     = 2'd1;
    localparam alu_op_t alu_op_pcaddui = 2'd2;
    localparam alu_op_t alu_op_add     = 2'd0;
    localparam alu_op_t alu_op_sub     = 2'd1;
    localparam alu_op_t alu_op_slt     = 2'd2;
    localparam alu_op_t alu_op_sltu    = 2'd3;
    localparam alu_op_t alu_op_and     = 2'd0;
    localparam alu_op_t alu_op_or      = 2'd1;
    localparam alu_op_t alu_op_xor     = 2'd2;
    localparam alu_op_t alu_op_nor     = 2'd3;
    localparam alu_op_t alu_op_sll     = 2'd0;
    localparam alu_op_t alu_op_srl     = 2'd1;
    localparam alu_op_t alu_op_sra     = 2'd2;

    typedef enum logic [`WIRED_MDU_OP_W-1:0] {
        mdu_mull, mdu_mulh, mdu_mulhu, mdu_div, mdu_mod, mdu_divu, mdu_modu
    } mdu_op_e;

    typedef enum logic {target_abs, target_rel} target_e;

    typedef enum logic [`WIRED_CMP_W-1:0] {
        cmp_nocond, cmp_eq, cmp_ne, cmp_lt, cmp_ge, cmp_ltu, cmp_geu
    } cmp_e;

    typedef struct packed {
        inst_t      inst;
        logic       alu_inst;
        logic       mdu_inst;
        logic       jump_inst;
        reg_r0_e    reg_type_r0;
        reg_r1_e    reg_type_r1;
        reg_w_e     reg_type_w;
        imm_e       imm_type;
        addr_imm_e  addr_imm_type;
        alu_grand_e alu_grand_op;
        alu_op_t    alu_op;
        mdu_op_e    mdu_op;
        target_e    target_type;
        cmp_e       cmp_type;
    } decoded_t;

    // result of one group decoder
    typedef struct packed {
        logic     hit;
        decoded_t dec;
    } group_out_t;

    localparam decoded_t dec_default = '{
        inst:          '0,
        alu_inst:      1'b0,
        mdu_inst:      1'b0,
        jump_inst:     1'b0,
        reg_type_r0:   reg_r0_none,
        reg_type_r1:   reg_r1_none,
        reg_type_w:    reg_w_none,
        imm_type:      imm_u5,
        addr_imm_type: addr_imm_s26,
        alu_grand_op:  alu_grand_li,
        alu_op:        alu_op_pcplus4,
        mdu_op:        mdu_mull,
        target_type:   target_abs,
        cmp_type:      cmp_nocond
    };

endpackage

//--- hdl/wired_reg_alu_decoder.sv
`include "wired_cfg.svh"

module wired_reg_alu_decoder (
    input  wired_pkg::inst_t    inst_i,
    output logic                hit_o,
    output wired_pkg::decoded_t dec_o
);

    wired_pkg::op17_t op17;

    assign op17 = inst_i[`WIRED_OP6_MSB:`WIRED_OP17_LSB];

    always_comb begin
        dec_o = wired_pkg::dec_default;
        dec_o.inst = inst_i;
        dec_o.reg_type_r0 = wired_pkg::reg_r0_rk;
        dec_o.reg_type_r1 = wired_pkg::reg_r1_rj;
        dec_o.reg_type_w = wired_pkg::reg_w_rd;
        hit_o = 1'b1;
        unique case (op17)
            17'b00000000000100000: begin
                dec_o.alu_grand_op = wired_pkg::alu_grand_int;
                dec_o.alu_op = wired_pkg::alu_op_add;
            end
            17'b00000000000100010: begin
                dec_o.alu_grand_op = wired_pkg::alu_grand_int;
                dec_o.alu_op = wired_pkg::alu_op_sub;
            end
            17'b00000000000100100: begin
                dec_o.alu_grand_op = wired_pkg::alu_grand_int;
                dec_o.alu_op = wired_pkg::alu_op_slt;
            end
            17'b00000000000100101: begin
                dec_o.alu_grand_op = wired_pkg::alu_grand_int;
                dec_o.alu_op = wired_pkg::alu_op_sltu;
            end
            17'b00000000000101000: begin
                dec_o.alu_grand_op = wired_pkg::alu_grand_bw;
                dec_o.alu_op = wired_pkg::alu_op_nor;
            end
            17'b00000000000101001: begin
                dec_o.alu_grand_op = wired_pkg::alu_grand_bw;
                dec_o.alu_op = wired_pkg::alu_op_and;
            end
            17'b00000000000101010: begin
                dec_o.alu_grand_op = wired_pkg::alu_grand_bw;
                dec_o.alu_op = wired_pkg::alu_op_or;
            end
            17'b00000000000101011: begin
                dec_o.alu_grand_op = wired_pkg::alu_grand_bw;
                dec_o.alu_op = wired_pkg::alu_op_xor;
            end
            17'b00000000000101110: begin
                dec_o.alu_grand_op = wired_pkg::alu_grand_sft;
                dec_o.alu_op = wired_pkg::alu_op_sll;
            end
            17'b00000000000101111: begin
                dec_o.alu_grand_op = wired_pkg::alu_grand_sft;
                dec_o.alu_op = wired_pkg::alu_op_srl;
            end
            17'b00000000000110000: begin
                dec_o.alu_grand_op = wired_pkg::alu_grand_sft;
                dec_o.alu_op = wired_pkg::alu_op_sra;
            end
            // multiplies also carry the int family
            17'b00000000000111000: begin
                dec_o.mdu_inst = 1'b1;
                dec_o.alu_grand_op = wired_pkg::alu_grand_int;
                dec_o.mdu_op = wired_pkg::mdu_mull;
            end
            17'b00000000000111001: begin
                dec_o.mdu_inst = 1'b1;
                dec_o.alu_grand_op = wired_pkg::alu_grand_int;
                dec_o.mdu_op = wired_pkg::mdu_mulh;
            end
            17'b00000000000111010: begin
                dec_o.mdu_inst = 1'b1;
                dec_o.alu_grand_op = wired_pkg::alu_grand_int;
                dec_o.mdu_op = wired_pkg::mdu_mulhu;
            end
            17'b00000000001000000: begin
                dec_o.mdu_inst = 1'b1;
                dec_o.mdu_op = wired_pkg::mdu_div;
            end
            17'b00000000001000001: begin
                dec_o.mdu_inst = 1'b1;
                dec_o.mdu_op = wired_pkg::mdu_mod;
            end
            17'b00000000001000010: begin
                dec_o.mdu_inst = 1'b1;
                dec_o.mdu_op = wired_pkg::mdu_divu;
            end
            17'b00000000001000011: begin
                dec_o.mdu_inst = 1'b1;
                dec_o.mdu_op = wired_pkg::mdu_modu;
            end
            default: hit_o = 1'b0;
        endcase
        // everything else that hits goes to the alu
        dec_o.alu_inst = hit_o & ~dec_o.mdu_inst;
        if (!hit_o) begin
            dec_o = wired_pkg::dec_default;
            dec_o.inst = inst_i;
        end
    end

endmodule

//--- verif/wired_decode_stage_props.sv
module wired_decode_stage_props (
    input logic                clk,
    input logic                rst_n_i,
    input logic                decoded_valid_o,
    input wired_pkg::decoded_t decoded_o,
    input logic                decode_err_o
);

    // assertion failures so far
    int fail_cnt = 0;

    // valid stays low through reset and the cycle after
    a_valid_reset: assert property (@(posedge clk) !rst_n_i |=> !decoded_valid_o)
        else begin
            fail_cnt++;
            $error("decoded_valid_o high after a reset cycle");
        end

    a_err_no_unit: assert property (@(posedge clk) disable iff (!rst_n_i)
        decode_err_o |-> !(decoded_o.alu_inst | decoded_o.mdu_inst | decoded_o.jump_inst))
        else begin
            fail_cnt++;
            $error("unit flag set together with decode error");
        end

    a_one_unit: assert property (@(posedge clk) disable iff (!rst_n_i)
        $onehot0({decoded_o.alu_inst, decoded_o.mdu_inst, decoded_o.jump_inst}))
        else begin
            fail_cnt++;
            $error("more than one unit flag set");
        end

endmodule

bind wired_decode_stage wired_decode_stage_props u_props (.*);

//--- verif/wired_decode_stage_tb.sv
`include "wired_cfg.svh"

module wired_decode_stage_tb;

    typedef struct packed {
        logic [63:0]         t;
        logic                valid;
        wired_pkg::decoded_t dec;
        logic                err;
    } exp_t;

    // legal opcodes top-aligned in 17 bits
    localparam logic [16:0] op_tab [38] = '{
        17'h09800, 17'h0a000, 17'h0a800, 17'h0b000, 17'h0b800, 17'h0c000, 17'h0c800,
        17'h0d000, 17'h0d800, 17'h02800, 17'h03800, 17'h00400, 17'h00480, 17'h00500,
        17'h00680, 17'h00700, 17'h00780, 17'h00081, 17'h00089, 17'h00091, 17'h00020,
        17'h00022, 17'h00024, 17'h00025, 17'h00028, 17'h00029, 17'h0002a, 17'h0002b,
        17'h0002e, 17'h0002f, 17'h00030, 17'h00038, 17'h00039, 17'h0003a, 17'h00040,
        17'h00041, 17'h00042, 17'h00043
    };
    // opcode length in bits for each table entry
    localparam int op_len [38] = '{
        6, 6, 6, 6, 6, 6, 6, 6, 6, 7, 7, 10, 10, 10, 10, 10, 10, 17, 17,
        17, 17, 17, 17, 17, 17, 17, 17, 17, 17, 17, 17, 17, 17, 17, 17, 17, 17, 17
    };

    logic                clk = 1'b0;
    logic                rst_n_i;
    logic                inst_valid_i;
    wired_pkg::inst_t    inst_i;
    logic                decoded_valid_o;
    wired_pkg::decoded_t decoded_o;
    logic                decode_err_o;

    logic [31:0] lfsr_state = 32'd78421;
    exp_t        exp_q [$];
    exp_t        item;
    exp_t        last;
    int          mismatch_cnt = 0;
    int          other_cnt = 0;

    always #5 clk = ~clk;

    wired_decode_stage u_wired_decode_stage (.*);

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check_value(input string what, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("Fail at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    function automatic exp_t decode_ref(input wired_pkg::inst_t w);
        exp_t        e;
        logic [5:0]  op6;
        logic [16:0] op17;
        logic [2:0]  sub;
        logic [1:0]  kind;
        logic [1:0]  g;
        logic [1:0]  o;
        logic [2:0]  m;
        op6 = w[`WIRED_OP6_MSB:`WIRED_OP6_LSB];
        op17 = w[`WIRED_OP6_MSB:`WIRED_OP17_LSB];
        sub = w[24:22];
        e = '0;
        e.dec = wired_pkg::dec_default;
        e.dec.inst = w;
        if (op6 >= 6'h13 && op6 <= 6'h1b) begin
            e.dec.jump_inst = 1'b1;
            e.dec.target_type = wired_pkg::target_rel;
            if (op6 == 6'h13) begin
                e.dec.reg_type_r1 = wired_pkg::reg_r1_rj;
                e.dec.reg_type_w = wired_pkg::reg_w_rd;
                e.dec.addr_imm_type = wired_pkg::addr_imm_s16;
                e.dec.target_type = wired_pkg::target_abs;
            end else if (op6 == 6'h15) begin
                e.dec.reg_type_w = wired_pkg::reg_w_bl1;
            end else if (op6 >= 6'h16) begin
                e.dec.cmp_type = wired_pkg::cmp_e'(4'(op6 - 6'h15));
                e.dec.reg_type_r0 = wired_pkg::reg_r0_rd;
                e.dec.reg_type_r1 = wired_pkg::reg_r1_rj;
                e.dec.addr_imm_type = wired_pkg::addr_imm_s16;
            end
        end else if (w[31:25] == 7'h0a || w[31:25] == 7'h0e) begin
            e.dec.alu_inst = 1'b1;
            e.dec.reg_type_r0 = wired_pkg::reg_r0_imm;
            e.dec.reg_type_w = wired_pkg::reg_w_rd;
            e.dec.imm_type = wired_pkg::imm_s20;
            e.dec.alu_op = w[27] ? wired_pkg::alu_op_pcaddui : wired_pkg::alu_op_lui;
        end else if (w[31:25] == 7'h01 && sub != 3'd3 && sub != 3'd4) begin
            e.dec.alu_inst = 1'b1;
            e.dec.reg_type_r0 = wired_pkg::reg_r0_imm;
            e.dec.reg_type_r1 = wired_pkg::reg_r1_rj;
            e.dec.reg_type_w = wired_pkg::reg_w_rd;
            e.dec.imm_type = sub[2] ? wired_pkg::imm_u12 : wired_pkg::imm_s12;
            e.dec.alu_grand_op = sub[2] ? wired_pkg::alu_grand_bw : wired_pkg::alu_grand_int;
            if (sub[2])
                e.dec.alu_op = 2'(sub - 3'd5);
            else
                e.dec.alu_op = (sub == 3'd2) ? wired_pkg::alu_op_add : 2'(sub + 3'd2);
        end else if (op17 == 17'h81 || op17 == 17'h89 || op17 == 17'h91) begin
            e.dec.alu_inst = 1'b1;
            e.dec.reg_type_r0 = wired_pkg::reg_r0_imm;
            e.dec.reg_type_r1 = wired_pkg::reg_r1_rj;
            e.dec.reg_type_w = wired_pkg::reg_w_rd;
            e.dec.alu_grand_op = wired_pkg::alu_grand_sft;
            e.dec.alu_op = op17[4:3];
        end else begin
            kind = 2'd0;
            g = '0;
            o = '0;
            m = '0;
            case (op17)
                17'h20: {kind, g, o} = {2'd1, wired_pkg::alu_grand_int, wired_pkg::alu_op_add};
                17'h22: {kind, g, o} = {2'd1, wired_pkg::alu_grand_int, wired_pkg::alu_op_sub};
                17'h24: {kind, g, o} = {2'd1, wired_pkg::alu_grand_int, wired_pkg::alu_op_slt};
                17'h25: {kind, g, o} = {2'd1, wired_pkg::alu_grand_int, wired_pkg::alu_op_sltu};
                17'h28: {kind, g, o} = {2'd1, wired_pkg::alu_grand_bw, wired_pkg::alu_op_nor};
                17'h29: {kind, g, o} = {2'd1, wired_pkg::alu_grand_bw, wired_pkg::alu_op_and};
                17'h2a: {kind, g, o} = {2'd1, wired_pkg::alu_grand_bw, wired_pkg::alu_op_or};
                17'h2b: {kind, g, o} = {2'd1, wired_pkg::alu_grand_bw, wired_pkg::alu_op_xor};
                17'h2e: {kind, g, o} = {2'd1, wired_pkg::alu_grand_sft, wired_pkg::alu_op_sll};
                17'h2f: {kind, g, o} = {2'd1, wired_pkg::alu_grand_sft, wired_pkg::alu_op_srl};
                17'h30: {kind, g, o} = {2'd1, wired_pkg::alu_grand_sft, wired_pkg::alu_op_sra};
                17'h38: {kind, g, m} = {2'd2, wired_pkg::alu_grand_int, wired_pkg::mdu_mull};
                17'h39: {kind, g, m} = {2'd2, wired_pkg::alu_grand_int, wired_pkg::mdu_mulh};
                17'h3a: {kind, g, m} = {2'd2, wired_pkg::alu_grand_int, wired_pkg::mdu_mulhu};
                17'h40: {kind, g, m} = {2'd2, wired_pkg::alu_grand_li, wired_pkg::mdu_div};
                17'h41: {kind, g, m} = {2'd2, wired_pkg::alu_grand_li, wired_pkg::mdu_mod};
                17'h42: {kind, g, m} = {2'd2, wired_pkg::alu_grand_li, wired_pkg::mdu_divu};
                17'h43: {kind, g, m} = {2'd2, wired_pkg::alu_grand_li, wired_pkg::mdu_modu};
                default: kind = 2'd0;
            endcase
            if (kind == 2'd0) begin
                e.err = 1'b1;
            end else begin
                e.dec.alu_inst = (kind == 2'd1);
                e.dec.mdu_inst = (kind == 2'd2);
                e.dec.reg_type_r0 = wired_pkg::reg_r0_rk;
                e.dec.reg_type_r1 = wired_pkg::reg_r1_rj;
                e.dec.reg_type_w = wired_pkg::reg_w_rd;
                e.dec.alu_grand_op = wired_pkg::alu_grand_e'(g);
                e.dec.alu_op = o;
                e.dec.mdu_op = wired_pkg::mdu_op_e'(m);
            end
        end
        return e;
    endfunction

    // an item is due once the latch edge after its drive edge has passed
    always @(negedge clk) begin
        if (exp_q.size() > 0 && exp_q[0].t + 64'd10 <= $time) begin
            item = exp_q.pop_front();
            check_value("decoded_valid_o", 128'(decoded_valid_o), 128'(item.valid));
            if (item.valid)
                last = item;
            check_value("decoded_o", 128'(decoded_o), 128'(last.dec));
            check_value("decode_err_o", 128'(decode_err_o), 128'(last.err));
        end
    end

    initial begin
        logic [31:0] word;
        logic [31:0] mode;
        logic [31:0] pick;
        logic [31:0] vbits;
        logic [31:0] mask;
        exp_t        e;
        int          idx;
        int          waited;
        int          prop_fails;
        rst_n_i = 1'b0;
        inst_valid_i = 1'b0;
        inst_i = '0;
        last = '0;
        last.dec = wired_pkg::dec_default;
        repeat (3) @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);
        check_value("reset decoded_valid_o", 128'(decoded_valid_o), 128'(0));
        check_value("reset decode_err_o", 128'(decode_err_o), 128'(0));
        check_value("reset decoded_o", 128'(decoded_o), 128'(wired_pkg::dec_default));
        for (int cyc = 0; cyc < 3000; cyc++) begin
            @(posedge clk);
            take_bits(32, word);
            take_bits(1, mode);
            if (mode[0]) begin
                take_bits(6, pick);
                idx = int'(pick % 32'd38);
                mask = ~(32'hffffffff >> op_len[idx]);
                word = (word & ~mask) | ({op_tab[idx], 15'b0} & mask);
            end
            take_bits(2, vbits);
            inst_valid_i <= (vbits[1:0] != 2'b00);
            inst_i <= word;
            e = decode_ref(word);
            e.valid = (vbits[1:0] != 2'b00);
            e.t = $time;
            exp_q.push_back(e);
        end
        @(posedge clk);
        inst_valid_i <= 1'b0;
        waited = 0;
        while (exp_q.size() > 0 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() > 0) begin
            other_cnt++;
            $display("timed out waiting for the expected queue to drain");
        end
        prop_fails = u_wired_decode_stage.u_props.fail_cnt;
        $display("errors: %0d mismatches, %0d assertion failures, %0d other",
                 mismatch_cnt, prop_fails, other_cnt);
        if (mismatch_cnt == 0 && prop_fails == 0 && other_cnt == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule
